// File: fetch.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_bus_if.sv
verilog/fetch_cfg_regs.sv
verilog/fetch_unit.sv
verilog/inst_mem.sv
verilog/fetch_top.sv
verif/fetch_clk_gen.sv
verif/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_bus_if.sv
      - verilog/fetch_cfg_regs.sv
      - verilog/fetch_unit.sv
      - verilog/inst_mem.sv
      - verilog/fetch_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/fetch_clk_gen.sv
      - verif/fetch_tb.sv

// File: verif/fetch_tb.sv
`include "fetch_params.svh"
`timescale 1ns/100ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int TIMEOUT   = 2000;
    localparam int MEM_WORDS = 2**`MEM_DEPTH_LOG2;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        redirect_valid;
    inst_addr_t  redirect_pc;
    logic        out_valid;
    inst_addr_t  out_pc;
    inst_word_t  out_inst;
    logic        out_ready;

    inst_word_t  shadow [MEM_WORDS];
    inst_addr_t  exp_pc;
    inst_word_t  exp_inst;
    inst_addr_t  prev_pc;
    inst_word_t  prev_inst;
    int          accept_count;
    logic [31:0] rng_state;

    fetch_clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    fetch_top dut_i (
        .clk              (clk),
        .reset            (reset),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .paddr_i          (paddr),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .pready_o         (pready),
        .pslverr_o        (pslverr),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .out_valid_o      (out_valid),
        .out_pc_o         (out_pc),
        .out_inst_o       (out_inst),
        .out_ready_i      (out_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    // Reference model for the expected PC and the decode handshake count
    always @(posedge clk) begin
        if (reset) begin
            accept_count <= 0;
        end else if (redirect_valid) begin
            exp_pc <= redirect_pc;
        end else if (out_valid && out_ready) begin
            exp_pc       <= exp_pc + 32'd4;
            accept_count <= accept_count + 1;
        end
        prev_pc   <= out_pc;
        prev_inst <= out_inst;
    end

    assign exp_inst = shadow[exp_pc[`MEM_DEPTH_LOG2+1:2]];

    pc_follows_model: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_pc == exp_pc)
        else report_mismatch("out_pc", $sampled(out_pc), $sampled(exp_pc));

    inst_matches_memory: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_inst == exp_inst)
        else report_mismatch("out_inst", $sampled(out_inst), $sampled(exp_inst));

    valid_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect_valid |=> out_valid)
        else report_mismatch("out_valid", $sampled(out_valid), 1'b1);

    pc_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect_valid |=> out_pc == prev_pc)
        else report_mismatch("out_pc", $sampled(out_pc), $sampled(prev_pc));

    inst_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect_valid |=> out_inst == prev_inst)
        else report_mismatch("out_inst", $sampled(out_inst), $sampled(prev_inst));

    // Setup phase then access phase with the result sampled mid-cycle
    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int t;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        t = 0;
        @(negedge clk);
        while (!pready) begin
            t++;
            if (t > TIMEOUT) begin
                stop_run("APB access never completed, pready stayed low");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr", err, 1'b0);
    endtask

    task automatic reg_read_check(input apb_addr_t addr, input logic [31:0] exp,
                                  input string name);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        check_value("pslverr", err, 1'b0);
        check_value(name, rd, exp);
    endtask

    task automatic start_fetch(input inst_addr_t boot);
        reg_write(`REG_BOOT_PC, boot);
        exp_pc = boot;
        reg_write(`REG_CTRL, 32'h1);
    endtask

    task automatic run_accepts(input int n, input logic random_ready);
        int target;
        int t;
        target = accept_count + n;
        t = 0;
        while (accept_count < target) begin
            @(posedge clk);
            #1;
            out_ready = random_ready ? ((rand_next() % 3) != 0) : 1'b1;
            t++;
            if (t > TIMEOUT) begin
                stop_run("Timed out waiting for decode to accept instructions");
            end
        end
    endtask

    // Phase 0 hits HOLD, 1 hits REQ, 2 hits WAIT
    task automatic redirect_at(input int phase);
        inst_addr_t target;
        int         t;
        target    = rand_next() & 32'hFFFF_FFFC;
        out_ready = 1'b0;
        t = 0;
        @(negedge clk);
        while (!out_valid) begin
            t++;
            if (t > TIMEOUT) begin
                stop_run("Timed out waiting for out_valid before a redirect");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (phase != 0) begin
            out_ready = 1'b1;
            @(posedge clk);
            #1;
            out_ready = 1'b0;
            if (phase == 2) begin
                @(posedge clk);
                #1;
            end
        end
        // out_ready high too, so in HOLD the redirect must win
        redirect_valid = 1'b1;
        redirect_pc    = target;
        out_ready      = 1'b1;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    task automatic drain();
        int quiet;
        int t;
        out_ready = 1'b1;
        reg_write(`REG_CTRL, 32'h0);
        quiet = 0;
        t = 0;
        while (quiet < 16) begin
            @(negedge clk);
            quiet = out_valid ? 0 : quiet + 1;
            t++;
            if (t > TIMEOUT) begin
                stop_run("Fetch unit did not go idle after fetch was disabled");
            end
        end
    endtask

    initial begin
        int          t;
        logic [31:0] rd;
        logic        err;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        out_ready      = 1'b0;
        exp_pc         = '0;
        rng_state      = 32'd10220;
        t = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                stop_run("Reset was never released");
            end
        end

        check_value("out_valid", out_valid, 1'b0);
        reg_read_check(`REG_CTRL, 32'h0, "ctrl");
        reg_read_check(`REG_FETCH_COUNT, 32'h0, "fetch_count");
        reg_read_check(`REG_LATENCY, 32'h0, "latency");

        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = rand_next();
        end
        reg_write(`REG_MEM_ADDR, 32'h0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            reg_write(`REG_MEM_DATA, shadow[i]);
        end
        // Load address wraps back to zero after a full memory
        reg_read_check(`REG_MEM_ADDR, 32'h0, "mem_addr");

        reg_write(`REG_LATENCY, 32'h0);
        start_fetch(32'h0000_0100);
        run_accepts(24, 1'b0);
        run_accepts(32, 1'b1);
        drain();

        reg_write(`REG_LATENCY, 32'h7);
        reg_read_check(`REG_LATENCY, 32'h7, "latency");
        start_fetch(rand_next() & 32'hFFFF_FFFC);
        run_accepts(12, 1'b1);
        for (int p = 0; p < 3; p++) begin
            redirect_at(p);
            run_accepts(6, 1'b1);
        end
        drain();

        // Start near the top of memory so fetches wrap
        reg_write(`REG_LATENCY, 32'h0);
        start_fetch(32'h0000_03F0);
        run_accepts(8, 1'b1);
        for (int p = 0; p < 3; p++) begin
            redirect_at(p);
            run_accepts(4, 1'b1);
        end
        drain();

        reg_read_check(`REG_FETCH_COUNT, accept_count, "fetch_count");
        reg_read_check(`REG_CTRL, 32'h0, "ctrl");
        apb_access(1'b0, 8'h18, 32'h0, rd, err);
        check_value("pslverr", err, 1'b1);
        apb_access(1'b1, `REG_FETCH_COUNT, 32'h0000_DEAD, rd, err);
        check_value("pslverr", err, 1'b1);
        reg_read_check(`REG_FETCH_COUNT, accept_count, "fetch_count");

        $display("TEST OK");
        $finish;
    end

endmodule

// File: verif/fetch_clk_gen.sv
`timescale 1ns/100ps

module fetch_clk_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: verilog/fetch_top.sv
`include "fetch_params.svh"
`timescale 1ns/100ps

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  fetch_pkg::apb_addr_t   paddr_i,
    input  logic [`INST_WIDTH-1:0] pwdata_i,
    output logic [`INST_WIDTH-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic                   redirect_valid_i,
    input  fetch_pkg::inst_addr_t  redirect_pc_i,
    output logic                   out_valid_o,
    output fetch_pkg::inst_addr_t  out_pc_o,
    output fetch_pkg::inst_word_t  out_inst_o,
    input  logic                   out_ready_i
);
    import fetch_pkg::*;

    logic       enable;
    logic       start;
    inst_addr_t boot_pc;
    latency_t   latency;
    logic       mem_we;
    mem_index_t mem_waddr;
    inst_word_t mem_wdata;
    logic       accept;

    fetch_bus_if bus_i ();

    fetch_cfg_regs cfg_i (
        .clk         (clk),
        .reset       (reset),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .accept_i    (accept),
        .enable_o    (enable),
        .start_o     (start),
        .boot_pc_o   (boot_pc),
        .latency_o   (latency),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata)
    );

    fetch_unit unit_i (
        .clk              (clk),
        .reset            (reset),
        .enable_i         (enable),
        .start_i          (start),
        .boot_pc_i        (boot_pc),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .bus              (bus_i.requester),
        .out_valid_o      (out_valid_o),
        .out_pc_o         (out_pc_o),
        .out_inst_o       (out_inst_o),
        .out_ready_i      (out_ready_i),
        .accept_o         (accept)
    );

    inst_mem mem_i (
        .clk       (clk),
        .reset     (reset),
        .latency_i (latency),
        .we_i      (mem_we),
        .waddr_i   (mem_waddr),
        .wdata_i   (mem_wdata),
        .bus       (bus_i.responder)
    );

endmodule

// File: verilog/inst_mem.sv
`include "fetch_params.svh"
`timescale 1ns/100ps

module inst_mem (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::latency_t   latency_i,
    input  logic                  we_i,
    input  fetch_pkg::mem_index_t waddr_i,
    input  fetch_pkg::inst_word_t wdata_i,
    fetch_bus_if.responder        bus
);
    import fetch_pkg::*;

    inst_word_t mem_q [2**`MEM_DEPTH_LOG2];
    mem_index_t raddr;
    inst_word_t rdata_q;
    latency_t   count_q;
    logic       pending_q;
    logic       accept;

    // Upper address bits are ignored so fetches wrap
    assign raddr  = bus.req_addr[`MEM_DEPTH_LOG2+1:2];
    assign accept = bus.req_valid && bus.req_ready;

    assign bus.req_ready = !pending_q;
    assign bus.rsp_valid = pending_q && (count_q == '0);
    assign bus.rsp_data  = rdata_q;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem_q[raddr];
        end
    end

    // Response fires once the wait counter reaches zero
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
            count_q   <= '0;
        end else if (accept) begin
            pending_q <= 1'b1;
            count_q   <= latency_i;
        end else if (pending_q) begin
            if (count_q == '0) begin
                pending_q <= 1'b0;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    rsp_only_when_pending: assert property (@(posedge clk) disable iff (reset)
        bus.rsp_valid |-> pending_q && !bus.req_ready);

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  logic                  start_i,
    input  fetch_pkg::inst_addr_t boot_pc_i,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::inst_addr_t redirect_pc_i,
    fetch_bus_if.requester        bus,
    output logic                  out_valid_o,
    output fetch_pkg::inst_addr_t out_pc_o,
    output fetch_pkg::inst_word_t out_inst_o,
    input  logic                  out_ready_i,
    output logic                  accept_o
);
    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    inst_addr_t   pc_q;
    inst_addr_t   pc_d;
    logic         capture;

    assign out_valid_o = (state_q == HOLD);

    // Redirect wins over the decode handshake
    assign accept_o = out_valid_o && out_ready_i && !redirect_valid_i;

    // A redirect in REQ withdraws the request for the stale PC
    assign bus.req_valid = (state_q == REQ) && !redirect_valid_i;
    assign bus.req_addr  = pc_q;

    assign capture = (state_q == WAIT) && bus.rsp_valid && !redirect_valid_i;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    pc_d    = boot_pc_i;
                    state_d = REQ;
                end
            end
            REQ: begin
                if (redirect_valid_i) begin
                    pc_d = redirect_pc_i;
                end else if (bus.req_ready) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (redirect_valid_i) begin
                    pc_d = redirect_pc_i;
                    // Stale word arriving right now is simply not captured
                    state_d = bus.rsp_valid ? REQ : DISCARD;
                end else if (bus.rsp_valid) begin
                    state_d = HOLD;
                end
            end
            DISCARD: begin
                if (redirect_valid_i) begin
                    pc_d = redirect_pc_i;
                end
                if (bus.rsp_valid) begin
                    state_d = REQ;
                end
            end
            HOLD: begin
                if (redirect_valid_i) begin
                    pc_d    = redirect_pc_i;
                    state_d = REQ;
                end else if (out_ready_i) begin
                    pc_d    = pc_q + 32'd4;
                    state_d = enable_i ? REQ : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // Decode output slot
    always_ff @(posedge clk) begin
        if (capture) begin
            out_pc_o   <= pc_q;
            out_inst_o <= bus.rsp_data;
        end
    end

    out_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        out_valid_o |-> out_pc_o[1:0] == 2'b00);

    out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid_o && !out_ready_i && !redirect_valid_i
        |=> out_valid_o && $stable(out_pc_o) && $stable(out_inst_o));

    no_req_in_wait: assert property (@(posedge clk) disable iff (reset)
        state_q == WAIT |-> !bus.req_valid);

endmodule

// File: verilog/fetch_cfg_regs.sv
`include "fetch_params.svh"
`timescale 1ns/100ps

module fetch_cfg_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  fetch_pkg::apb_addr_t   paddr_i,
    input  logic [`INST_WIDTH-1:0] pwdata_i,
    output logic [`INST_WIDTH-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic                   accept_i,
    output logic                   enable_o,
    output logic                   start_o,
    output fetch_pkg::inst_addr_t  boot_pc_o,
    output fetch_pkg::latency_t    latency_o,
    output logic                   mem_we_o,
    output fetch_pkg::mem_index_t  mem_waddr_o,
    output fetch_pkg::inst_word_t  mem_wdata_o
);
    import fetch_pkg::*;

    logic                   access;
    logic                   wr;
    logic                   addr_hit;
    mem_index_t             mem_addr_q;
    logic [`INST_WIDTH-1:0] count_q;

    assign access   = psel_i && penable_i;
    assign wr       = access && pwrite_i;
    assign pready_o = 1'b1;

    always_comb begin
        addr_hit = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `REG_CTRL:        prdata_o[0] = enable_o;
            `REG_BOOT_PC:     prdata_o = boot_pc_o;
            `REG_LATENCY:     prdata_o[`LAT_WIDTH-1:0] = latency_o;
            `REG_MEM_ADDR:    prdata_o[`MEM_DEPTH_LOG2-1:0] = mem_addr_q;
            // Write only, reads as zero
            `REG_MEM_DATA:    ;
            `REG_FETCH_COUNT: prdata_o = count_q;
            default:          addr_hit = 1'b0;
        endcase
    end

    assign pslverr_o = access && (!addr_hit || (pwrite_i && paddr_i == `REG_FETCH_COUNT));

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_o   <= 1'b0;
            start_o    <= 1'b0;
            boot_pc_o  <= '0;
            latency_o  <= '0;
            mem_addr_q <= '0;
            mem_we_o   <= 1'b0;
            count_q    <= '0;
        end else begin
            start_o  <= 1'b0;
            mem_we_o <= 1'b0;
            if (accept_i) begin
                count_q <= count_q + 1'b1;
            end
            if (wr) begin
                case (paddr_i)
                    `REG_CTRL: begin
                        enable_o <= pwdata_i[0];
                        start_o  <= pwdata_i[0];
                    end
                    `REG_BOOT_PC:  boot_pc_o <= pwdata_i;
                    `REG_LATENCY:  latency_o <= pwdata_i[`LAT_WIDTH-1:0];
                    // MEM_ADDR is a word index, not a byte address
                    `REG_MEM_ADDR: mem_addr_q <= pwdata_i[`MEM_DEPTH_LOG2-1:0];
                    `REG_MEM_DATA: begin
                        mem_we_o   <= 1'b1;
                        mem_addr_q <= mem_addr_q + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Program load payload
    always_ff @(posedge clk) begin
        if (wr && paddr_i == `REG_MEM_DATA) begin
            mem_waddr_o <= mem_addr_q;
            mem_wdata_o <= pwdata_i;
        end
    end

    mem_we_one_per_access: assert property (@(posedge clk) disable iff (reset)
        mem_we_o && !access |=> !mem_we_o);

endmodule

// File: verilog/fetch_bus_if.sv
`timescale 1ns/100ps

interface fetch_bus_if;
    import fetch_pkg::*;

    // Request channel, one outstanding transfer at a time
    logic       req_valid;
    inst_addr_t req_addr;
    logic       req_ready;

    // Single-cycle response pulse
    logic       rsp_valid;
    inst_word_t rsp_data;

    modport requester (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport responder (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );

endinterface

// File: verilog/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // Program counter and instruction word
    typedef logic [`ADDR_WIDTH-1:0] inst_addr_t;
    typedef logic [`INST_WIDTH-1:0] inst_word_t;

    // Word index into the instruction memory
    typedef logic [`MEM_DEPTH_LOG2-1:0] mem_index_t;

    // Extra response wait cycles
    typedef logic [`LAT_WIDTH-1:0] latency_t;

    typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;

    // Fetch unit states
    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT,
        DISCARD,
        HOLD
    } fetch_state_e;

endpackage

// File: verilog/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Datapath widths
`define INST_WIDTH      32
`define ADDR_WIDTH      32

// Instruction memory holds 2**MEM_DEPTH_LOG2 words
`define MEM_DEPTH_LOG2  8
`define LAT_WIDTH       3

`define APB_ADDR_WIDTH  8

// APB register map, byte offsets
`define REG_CTRL        8'h00
`define REG_BOOT_PC     8'h04
`define REG_LATENCY     8'h08
`define REG_MEM_ADDR    8'h0C
`define REG_MEM_DATA    8'h10
`define REG_FETCH_COUNT 8'h14

`endif
